// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= board_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
SEED_FLAGS ?= +verilator+seed+1
VFLAGS     ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Board I/O counts
    localparam int num_buttons = 4;
    localparam int num_leds    = 6;

    typedef logic [7:0]             byte_t;     // One serial data byte
    typedef logic [num_leds-1:0]    leds_t;     // LED bits and the LED register
    typedef logic [num_buttons-1:0] buttons_t;  // Button levels or press pulses

    // Command opcode, carried in bits 7:6 of a received byte
    // Bits 5:0 hold the operand
    typedef enum logic [1:0] {
        op_write  = 2'b00,  // Load LED bits from operand
        op_read   = 2'b01,  // Reply with LED state
        op_toggle = 2'b10,  // XOR operand into LED bits
        op_nop    = 2'b11   // Ignored
    } csr_op_e;

endpackage

`default_nettype wire

// ==== source/board_top.sv ====
`default_nettype none

module board_top #(
    parameter int clock_freq     = 62_500_000,
    parameter int baud_rate      = 115_200,
    parameter int sample_cnt_max = 31_250,  // 500 us sample period at 62.5 MHz
    parameter int pulse_cnt_max  = 200      // 100 ms of steady press
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire board_pkg::buttons_t buttons,
    input  wire logic                serial_rx,
    output logic                     serial_tx,
    output board_pkg::leds_t         leds
);

    board_pkg::buttons_t presses;
    logic                rx_valid;
    board_pkg::byte_t    rx_data;
    logic                tx_start;
    board_pkg::byte_t    tx_data;
    logic                tx_busy;

    button_parser #(
        .width          (board_pkg::num_buttons),
        .sample_cnt_max (sample_cnt_max),
        .pulse_cnt_max  (pulse_cnt_max)
    ) bp (
        .clk     (clk),
        .rst_n   (rst_n),
        .buttons (buttons),
        .presses (presses)
    );

    uart_rx #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .serial_rx (serial_rx),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data)
    );

    csr_ctrl ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .presses  (presses),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .leds     (leds)       // Straight to the board pins
    );

    uart_tx #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .serial_tx (serial_tx)
    );

endmodule

`default_nettype wire

// ==== source/button_parser.sv ====
`default_nettype none

module button_parser #(
    parameter int width          = 4,
    parameter int sample_cnt_max = 31_250,  // Clocks between samples
    parameter int pulse_cnt_max  = 200      // High samples that qualify a press
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire board_pkg::buttons_t buttons,
    output board_pkg::buttons_t      presses
);

    localparam int sample_w = $clog2(sample_cnt_max + 1);
    localparam int pulse_w  = $clog2(pulse_cnt_max + 1);

    board_pkg::buttons_t btn_meta, btn_sync;  // Two-flop synchronizer
    logic [sample_w-1:0] sample_cnt;
    logic                sample_tick;
    logic [pulse_w-1:0]  pulse_cnt [width];   // One saturating counter per button

    assign sample_tick = (sample_cnt == sample_w'(sample_cnt_max - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
        end
    end

    // Shared sample timer for all buttons
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_cnt <= '0;
        end else if (sample_tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < width; i++) begin
                pulse_cnt[i] <= '0;
            end
            presses <= '0;
        end else begin
            presses <= '0;                       // Pulses last one cycle
            if (sample_tick) begin
                for (int i = 0; i < width; i++) begin
                    if (!btn_sync[i]) begin
                        pulse_cnt[i] <= '0;      // Low sample re-arms the bit
                    end else if (pulse_cnt[i] != pulse_w'(pulse_cnt_max)) begin
                        pulse_cnt[i] <= pulse_cnt[i] + 1'b1;
                        // Fires only on the step into saturation
                        presses[i] <= (pulse_cnt[i] == pulse_w'(pulse_cnt_max - 1));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_ctrl.sv ====
`default_nettype none

module csr_ctrl (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                rx_valid,
    input  wire board_pkg::byte_t    rx_data,
    input  wire board_pkg::buttons_t presses,
    input  wire logic                tx_busy,
    output logic                     tx_start,
    output board_pkg::byte_t         tx_data,
    output board_pkg::leds_t         leds
);

    // Reply FSM for read commands
    typedef enum logic [1:0] {
        idle,
        pending,  // Waiting for the transmitter to go idle
        send      // tx_start high for this cycle
    } reply_state_e;

    reply_state_e        state;
    reply_state_e        state_next;
    board_pkg::csr_op_e  op;
    board_pkg::leds_t    operand;
    board_pkg::leds_t    press_mask;
    board_pkg::leds_t    leds_cmd;   // After the command only
    board_pkg::leds_t    leds_next;
    logic                rd_req;

    assign op         = board_pkg::csr_op_e'(rx_data[7:6]);
    assign operand    = rx_data[board_pkg::num_leds-1:0];
    assign press_mask = board_pkg::leds_t'(presses);  // Buttons hit the low bits
    assign rd_req     = rx_valid && (op == board_pkg::op_read);
    assign tx_start   = (state == send);

    always_comb begin
        leds_cmd = leds;
        if (rx_valid) begin
            case (op)
                board_pkg::op_write:  leds_cmd = operand;
                board_pkg::op_toggle: leds_cmd = leds ^ operand;
                default:              leds_cmd = leds;  // Read and nop leave LEDs alone
            endcase
        end
        leds_next = leds_cmd ^ press_mask;  // Press toggles land on top of the command
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leds <= '0;
        end else begin
            leds <= leds_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle:    if (rd_req) state_next = tx_busy ? pending : send;
            pending: if (!tx_busy) state_next = send;
            send:    state_next = rd_req ? pending : idle;  // Busy rises next cycle
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Snapshot of LEDs before this cycle's updates; a read during pending is dropped
    always_ff @(posedge clk) begin
        if (rd_req && state != pending) begin
            tx_data <= {2'b00, leds};
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none

module uart_rx #(
    parameter int clock_freq = 62_500_000,
    parameter int baud_rate  = 115_200
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        serial_rx,
    output logic             rx_valid,
    output board_pkg::byte_t rx_data
);

    localparam int cycles_per_bit = clock_freq / baud_rate;
    localparam int half_bit       = cycles_per_bit / 2;
    localparam int cnt_w          = $clog2(cycles_per_bit);

    logic                rx_meta;
    logic                rx_sync;
    logic                rx_last;   // Delayed copy for falling edge detect
    logic                busy;
    logic [cnt_w-1:0]    clk_cnt;
    logic [3:0]          bit_idx;   // 0 start, 1 to 8 data, 9 stop
    logic                bit_done;
    board_pkg::byte_t    data_sr;

    // Start bit is checked at its centre, later bits one full period apart
    assign bit_done = (bit_idx == 4'd0) ? (clk_cnt == cnt_w'(half_bit - 1))
                                        : (clk_cnt == cnt_w'(cycles_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // Line idles high
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= serial_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                clk_cnt <= '0;
                bit_idx <= '0;
                busy    <= rx_last && !rx_sync;  // Falling edge starts a frame
            end else if (!bit_done) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync) begin
                    busy <= 1'b0;                // Glitch, not a real start bit
                end
                if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync;         // Low stop bit drops the byte
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (busy && bit_done && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            data_sr <= {rx_sync, data_sr[7:1]};
        end
        if (busy && bit_done && bit_idx == 4'd9) begin
            rx_data <= data_sr;
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`default_nettype none

module uart_tx #(
    parameter int clock_freq = 62_500_000,
    parameter int baud_rate  = 115_200
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             tx_start,
    input  wire board_pkg::byte_t tx_data,
    output logic                  tx_busy,
    output logic                  serial_tx
);

    localparam int cycles_per_bit = clock_freq / baud_rate;
    localparam int cnt_w          = $clog2(cycles_per_bit);

    logic [9:0]       frame;    // Stop, data, start; shifted out from bit 0
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic             bit_end;

    assign bit_end = (clk_cnt == cnt_w'(cycles_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_busy   <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            serial_tx <= 1'b1;
        end else begin
            serial_tx <= tx_busy ? frame[0] : 1'b1;  // Output flop, idle high
            if (!tx_busy) begin
                clk_cnt <= '0;
                bit_idx <= '0;
                tx_busy <= tx_start;
            end else if (!bit_end) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd9) begin
                    tx_busy <= 1'b0;                 // Stop bit done
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && bit_end) begin
            frame <= {1'b1, frame[9:1]};             // Next bit, fill with idle
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/board_pkg.sv
source/button_parser.sv
source/uart_rx.sv
source/uart_tx.sv
source/csr_ctrl.sv
source/board_top.sv
verification/board_tb.sv

// ==== verification/board_tb.sv ====
`default_nettype none

module board_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bit_cycles = 10;              // 25 MHz clock, 2.5 Mbaud
    localparam int reply_wait = 25 * bit_cycles; // Command frame plus 15 bit times

    logic                clk = 1'b0;
    logic                rst_n;
    board_pkg::buttons_t buttons;
    logic                serial_rx;
    logic                serial_tx;
    board_pkg::leds_t    leds;

    board_pkg::leds_t    leds_model;             // Expected LED register
    logic [31:0]         rng_state;
    int                  errors;
    int                  checks;

    always #20 clk = ~clk;                       // 40 ns period

    board_top #(
        .clock_freq     (25_000_000),
        .baud_rate      (2_500_000),
        .sample_cnt_max (4),
        .pulse_cnt_max  (3)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .buttons   (buttons),
        .serial_rx (serial_rx),
        .serial_tx (serial_tx),
        .leds      (leds)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Sends an 8N1 frame LSB first; a low stop_bit makes a framing error
    task automatic send_byte(input board_pkg::byte_t data, input logic stop_bit);
        serial_rx = 1'b0;
        repeat (bit_cycles) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            serial_rx = data[i];
            repeat (bit_cycles) @(negedge clk);
        end
        serial_rx = stop_bit;
        repeat (bit_cycles) @(negedge clk);
        serial_rx = 1'b1;                        // Back to idle
    endtask

    // Returns at the centre of the stop bit
    task automatic receive_byte(input int timeout_cycles, output board_pkg::byte_t data,
                                output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        data   = '0;
        while (serial_tx !== 1'b0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (serial_tx !== 1'b0) begin
            $display("Timeout: no start bit on serial_tx within %0d cycles", timeout_cycles);
            errors++;
            return;
        end
        repeat (bit_cycles / 2) @(negedge clk);  // Move to bit centre
        if (serial_tx !== 1'b0) begin
            $display("FAILED at %0t: start bit on serial_tx did not hold", $time);
            errors++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(negedge clk);
            data[i] = serial_tx;
        end
        repeat (bit_cycles) @(negedge clk);
        if (serial_tx !== 1'b1) begin
            $display("FAILED at %0t: stop bit on serial_tx is low", $time);
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic expect_line_idle(input int cycles);
        bit seen_low;
        seen_low = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (serial_tx !== 1'b1) seen_low = 1'b1;
        end
        checks++;
        if (seen_low) begin
            $display("FAILED at %0t: serial_tx left idle, no reply expected", $time);
            errors++;
        end
    endtask

    // Polls leds until they match the model or the timeout runs out
    task automatic check_leds(input int timeout_cycles);
        int waited;
        waited = 0;
        while (leds !== leds_model && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (leds !== leds_model) begin
            $display("FAILED at %0t: leds %b, expected %b", $time, leds, leds_model);
            errors++;
        end
    endtask

    task automatic run_command(input board_pkg::csr_op_e op, input board_pkg::leds_t operand);
        send_byte({op, operand}, 1'b1);
        if (op == board_pkg::op_write) leds_model = operand;
        else if (op == board_pkg::op_toggle) leds_model = leds_model ^ operand;
        check_leds(2 * bit_cycles);             // Up to 2 bit times past the stop bit
    endtask

    task automatic read_and_check(input board_pkg::leds_t operand);
        board_pkg::byte_t reply;
        bit               ok;
        fork
            send_byte({board_pkg::op_read, operand}, 1'b1);
            receive_byte(reply_wait, reply, ok);
        join
        checks++;
        if (ok && reply !== {2'b00, leds_model}) begin
            $display("FAILED at %0t: reply %h, expected %h", $time, reply, {2'b00, leds_model});
            errors++;
        end
        expect_line_idle(15 * bit_cycles);      // Exactly one reply byte
    endtask

    // Button high for the given cycles, then released and left to settle
    task automatic pulse_button(input int idx, input int cycles);
        buttons[idx] = 1'b1;
        repeat (cycles) @(negedge clk);
        buttons[idx] = 1'b0;
        repeat (40) @(negedge clk);
    endtask

    initial begin
        board_pkg::byte_t   reply_a;
        board_pkg::byte_t   reply_b;
        bit                 ok_a;
        bit                 ok_b;
        logic [31:0]        rnd;
        int                 idx;
        board_pkg::csr_op_e op;

        rst_n      = 1'b0;
        buttons    = '0;
        serial_rx  = 1'b1;
        leds_model = '0;
        rng_state  = 32'hb9df;
        errors     = 0;
        checks     = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        checks++;
        if (leds !== '0) begin
            $display("FAILED at %0t: leds %b after reset, expected 0", $time, leds);
            errors++;
        end
        expect_line_idle(50);

        // Random writes and toggles
        for (int n = 0; n < 12; n++) begin
            rnd = next_random();
            op  = rnd[8] ? board_pkg::op_toggle : board_pkg::op_write;
            run_command(op, rnd[5:0]);
        end

        // Reads after a fresh random value
        for (int n = 0; n < 4; n++) begin
            rnd = next_random();
            run_command(board_pkg::op_write, rnd[5:0]);
            read_and_check(rnd[13:8]);
        end

        // Second read lands while the first reply is still on the line
        rnd = next_random();
        fork
            begin
                send_byte({board_pkg::op_read, rnd[5:0]}, 1'b1);
                send_byte({board_pkg::op_read, rnd[11:6]}, 1'b1);
            end
            begin
                receive_byte(reply_wait, reply_a, ok_a);
                receive_byte(reply_wait, reply_b, ok_b);
            end
        join
        checks++;
        if (ok_a && reply_a !== {2'b00, leds_model}) begin
            $display("FAILED at %0t: first reply %h, expected %h", $time, reply_a,
                     {2'b00, leds_model});
            errors++;
        end
        checks++;
        if (ok_b && reply_b !== {2'b00, leds_model}) begin
            $display("FAILED at %0t: second reply %h, expected %h", $time, reply_b,
                     {2'b00, leds_model});
            errors++;
        end
        expect_line_idle(15 * bit_cycles);

        // Nop touches nothing
        rnd = next_random();
        fork
            send_byte({board_pkg::op_nop, rnd[5:0]}, 1'b1);
            expect_line_idle(10 * bit_cycles + 15 * bit_cycles);
        join
        check_leds(0);

        // Held buttons and short glitches
        for (int n = 0; n < 4; n++) begin
            rnd = next_random();
            idx = int'(rnd[1:0]);
            pulse_button(idx, 30 + int'(rnd[12:8]));  // Long hold still gives one toggle
            leds_model[idx] = ~leds_model[idx];
            check_leds(0);
            rnd = next_random();
            pulse_button(int'(rnd[1:0]), 1 + int'(rnd[15:8] % 8'd7));  // 1 to 7 cycles
            check_leds(0);
        end

        // A write with a low stop bit must not land, its value always differs from the LEDs
        for (int n = 0; n < 2; n++) begin
            rnd = next_random();
            send_byte({board_pkg::op_write, leds_model ^ {rnd[5:1], 1'b1}}, 1'b0);
            repeat (2 * bit_cycles) @(negedge clk);
            check_leds(0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
